/* line_bridge.f */
rtl/bridge_pkg.sv
rtl/line_ram.sv
rtl/request_reader.sv
rtl/response_writer.sv
rtl/line_bridge.sv
verification/line_bridge_tb.sv

/* Makefile */
# Verilator build and run for the line bridge testbench

VERILATOR ?= verilator
TOP       ?= line_bridge_tb
FILELIST  ?= line_bridge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= STATUS: PASS
VFLAGS    ?= --binary --timing --assert -j 0

SIM_EXE := $(BUILD_DIR)/$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

run: compile
	-$(SIM_EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/line_bridge_tb.sv */
// line bridge testbench, FIFO models around the DUT with a reference line memory
module line_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED = 50572;
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_TIMEOUT = 40000;
    localparam int RANDOM_REQS = 200;

    logic              itf;
    logic              arst_n;
    logic              in_empty;
    bridge_pkg::word_t in_data;
    logic              in_rd;
    logic              out_full;
    logic              out_wr;
    bridge_pkg::word_t out_data;

    // input fifo contents, front word is on in_data
    bridge_pkg::word_t in_q[$];
    // expected output words in request order
    bridge_pkg::word_t exp_q[$];
    bit                exp_ack_q[$];
    // reference copy of every line, word 0 first
    bridge_pkg::word_t ref_mem [bridge_pkg::LINES][bridge_pkg::WORDS_PER_LINE];

    int mismatch_count;
    int other_count;
    bit timed_out;
    bit hold_reset;

    line_bridge uut (
        .itf      (itf),
        .arst_n   (arst_n),
        .in_empty (in_empty),
        .in_data  (in_data),
        .in_rd    (in_rd),
        .out_full (out_full),
        .out_wr   (out_wr),
        .out_data (out_data)
    );

    // 8 ns clock
    initial begin
        itf = 1'b0;
        forever #4 itf = ~itf;
    end

    task automatic check_word(input bridge_pkg::word_t got, input bridge_pkg::word_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: data word got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_ack(input bridge_pkg::word_t got);
        bridge_pkg::word_t all_ones;
        // an acknowledge is every bit set
        all_ones = '1;
        if (got !== all_ones) begin
            mismatch_count++;
            $display("MISMATCH at %0t: ack word got %h expected %h", $time, got, all_ones);
        end
    endtask

    task automatic report_failure(input string msg);
        other_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // one clock of both fifo models
    // drive on the falling edge, sample 2 ns later while stable
    task automatic bus_cycle();
        bridge_pkg::word_t expect_word;
        bit expect_ack;
        @(negedge itf);
        arst_n = !hold_reset;
        in_data = (in_q.size() != 0) ? in_q[0] : bridge_pkg::word_t'($urandom);
        // a word is on offer during reset too, it must not be taken
        // random gaps, even inside a write burst
        in_empty = !hold_reset && ((in_q.size() == 0) || ($urandom_range(3) == 0));
        out_full = !hold_reset && ($urandom_range(2) == 0);
        #2;
        if (!arst_n) begin
            if (in_rd || out_wr) begin
                report_failure("in_rd or out_wr high during reset");
            end
        end else begin
            if (in_rd) begin
                if (in_empty) begin
                    report_failure("in_rd high while the input FIFO is empty");
                end else begin
                    void'(in_q.pop_front());
                end
            end
            if (out_wr) begin
                if (out_full) begin
                    report_failure("out_wr high while the output FIFO is full");
                end else if (exp_q.size() == 0) begin
                    report_failure("output word pushed with no response outstanding");
                end else begin
                    expect_word = exp_q.pop_front();
                    expect_ack = exp_ack_q.pop_front();
                    if (expect_ack) begin
                        check_ack(out_data);
                    end else begin
                        check_word(out_data, expect_word);
                    end
                end
            end
        end
    endtask

    // command word with random filler outside the decoded fields
    function automatic bridge_pkg::word_t make_cmd(input bridge_pkg::line_idx_t line,
                                                   input bit write);
        bridge_pkg::word_t cmd;
        cmd = $urandom;
        cmd[bridge_pkg::CMD_LINE_LSB +: $bits(bridge_pkg::line_idx_t)] = line;
        cmd[bridge_pkg::CMD_WRITE_BIT] = write;
        return cmd;
    endfunction

    task automatic queue_write(input bridge_pkg::line_idx_t line);
        bridge_pkg::word_t data;
        in_q.push_back(make_cmd(line, 1'b1));
        for (int i = 0; i < bridge_pkg::WORDS_PER_LINE; i++) begin
            data = $urandom;
            ref_mem[line][i] = data;
            in_q.push_back(data);
        end
        // one ack after the last data word
        exp_q.push_back(bridge_pkg::ACK_WORD);
        exp_ack_q.push_back(1'b1);
    endtask

    task automatic queue_read(input bridge_pkg::line_idx_t line);
        in_q.push_back(make_cmd(line, 1'b0));
        // words come back in the order they were written
        for (int i = 0; i < bridge_pkg::WORDS_PER_LINE; i++) begin
            exp_q.push_back(ref_mem[line][i]);
            exp_ack_q.push_back(1'b0);
        end
    endtask

    // run until every request is consumed and answered
    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while ((in_q.size() != 0 || exp_q.size() != 0) && cycles < limit) begin
            bus_cycle();
            cycles++;
        end
        if (in_q.size() != 0 || exp_q.size() != 0) begin
            report_failure($sformatf(
                "timeout after %0d cycles, %0d input and %0d output words left",
                cycles, in_q.size(), exp_q.size()));
            timed_out = 1'b1;
        end
    endtask

    initial begin
        bridge_pkg::line_idx_t line;
        bit do_write;
        void'($urandom(SEED));
        arst_n = 1'b0;
        in_empty = 1'b1;
        in_data = '0;
        out_full = 1'b0;
        hold_reset = 1'b1;
        mismatch_count = 0;
        other_count = 0;
        timed_out = 1'b0;
        repeat (RESET_CYCLES) bus_cycle();
        hold_reset = 1'b0;
        // quiet cycles, nothing may move
        repeat (4) bus_cycle();

        // fill every line once
        for (int l = 0; l < bridge_pkg::LINES; l++) begin
            queue_write(bridge_pkg::line_idx_t'(l));
        end
        wait_drain(DRAIN_TIMEOUT);

        if (!timed_out) begin
            // write then read back the same line
            queue_write(bridge_pkg::line_idx_t'(9));
            queue_read(bridge_pkg::line_idx_t'(9));
            line = '0;
            for (int n = 0; n < RANDOM_REQS; n++) begin
                // sometimes stay on the last line so a write chases a read
                if ($urandom_range(3) != 0) begin
                    line = bridge_pkg::line_idx_t'($urandom_range(bridge_pkg::LINES - 1));
                end
                do_write = ($urandom_range(1) == 1);
                if (do_write) begin
                    queue_write(line);
                end else begin
                    queue_read(line);
                end
            end
            wait_drain(DRAIN_TIMEOUT);
        end

        // stray words would show up here
        repeat (20) bus_cycle();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* rtl/line_bridge.sv */
// line bridge top, request reader and response writer around the line RAM
module line_bridge (
    input  logic              itf,
    input  logic              arst_n,
    input  logic              in_empty,
    input  bridge_pkg::word_t in_data,
    output logic              in_rd,
    input  logic              out_full,
    output logic              out_wr,
    output bridge_pkg::word_t out_data
);

    // reader to writer job handoff
    logic                  job_valid;
    logic                  job_ready;
    bridge_pkg::line_idx_t job_line;
    logic                  job_write;
    // writer still streaming, holds the reader's first beat write
    logic                  writer_busy;

    // ram write port
    logic                  wr_en;
    bridge_pkg::ram_addr_t wr_addr;
    bridge_pkg::beat_t     wr_beat;
    // ram read port
    logic                  rd_en;
    bridge_pkg::ram_addr_t rd_addr;
    bridge_pkg::beat_t     rd_beat;

    request_reader u_reader (
        .itf         (itf),
        .arst_n      (arst_n),
        .in_empty    (in_empty),
        .in_data     (in_data),
        .in_rd       (in_rd),
        .writer_busy (writer_busy),
        .job_ready   (job_ready),
        .job_valid   (job_valid),
        .job_line    (job_line),
        .job_write   (job_write),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_beat     (wr_beat)
    );

    response_writer u_writer (
        .itf         (itf),
        .arst_n      (arst_n),
        .job_valid   (job_valid),
        .job_line    (job_line),
        .job_write   (job_write),
        .job_ready   (job_ready),
        .writer_busy (writer_busy),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_beat     (rd_beat),
        .out_full    (out_full),
        .out_wr      (out_wr),
        .out_data    (out_data)
    );

    line_ram u_ram (
        .itf     (itf),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_beat (wr_beat),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_beat (rd_beat)
    );

endmodule

/* rtl/response_writer.sv */
// response writer, streams a line or an acknowledge word to the output FIFO
module response_writer (
    input  logic                  itf,
    input  logic                  arst_n,
    input  logic                  job_valid,
    input  bridge_pkg::line_idx_t job_line,
    input  logic                  job_write,
    output logic                  job_ready,
    output logic                  writer_busy,
    output logic                  rd_en,
    output bridge_pkg::ram_addr_t rd_addr,
    input  bridge_pkg::beat_t     rd_beat,
    input  logic                  out_full,
    output logic                  out_wr,
    output bridge_pkg::word_t     out_data
);

    typedef enum logic [2:0] {
        s_idle,
        s_fetch,
        s_low,
        s_high,
        s_ack
    } state_t;

    state_t state, next_state;

    // line of the current read job
    bridge_pkg::line_idx_t line_q;
    // beat held in the ram read register
    bridge_pkg::beat_idx_t beat_cnt;
    // beat to fetch this cycle
    bridge_pkg::beat_idx_t fetch_beat;
    logic last_beat;

    assign last_beat = (beat_cnt == bridge_pkg::beat_idx_t'(bridge_pkg::BEATS_PER_LINE - 1));
    assign job_ready = (state == s_idle);
    assign writer_busy = (state != s_idle);
    assign rd_addr = {line_q, fetch_beat};

    always_comb begin
        next_state = state;
        rd_en = 1'b0;
        out_wr = 1'b0;
        fetch_beat = beat_cnt;
        out_data = rd_beat[bridge_pkg::WORD_W-1:0];
        case (state)
            s_idle: begin
                if (job_valid) begin
                    // a write only needs its acknowledge
                    next_state = job_write ? s_ack : s_fetch;
                end
            end
            s_fetch: begin
                // first beat of the line
                rd_en = 1'b1;
                next_state = s_low;
            end
            s_low: begin
                out_data = rd_beat[bridge_pkg::WORD_W-1:0];
                if (!out_full) begin
                    out_wr = 1'b1;
                    next_state = s_high;
                end
            end
            s_high: begin
                out_data = rd_beat[bridge_pkg::BEAT_W-1:bridge_pkg::WORD_W];
                if (!out_full) begin
                    out_wr = 1'b1;
                    if (last_beat) begin
                        next_state = s_idle;
                    end else begin
                        // next beat loads as the high word leaves
                        rd_en = 1'b1;
                        fetch_beat = beat_cnt + 2'd1;
                        next_state = s_low;
                    end
                end
            end
            s_ack: begin
                out_data = bridge_pkg::ACK_WORD;
                if (!out_full) begin
                    out_wr = 1'b1;
                    next_state = s_idle;
                end
            end
            default: begin
                next_state = s_idle;
            end
        endcase
    end

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
            beat_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == s_idle) begin
                beat_cnt <= '0;
            end else if (rd_en && state == s_high) begin
                beat_cnt <= fetch_beat;
            end
        end
    end

    always_ff @(posedge itf) begin
        if (job_valid && job_ready) begin
            line_q <= job_line;
        end
    end

    ap_no_push_full: assert property (
        @(posedge itf) disable iff (!arst_n) out_wr |-> !out_full
    ) else $error("response_writer: push while output fifo full");

endmodule

/* rtl/request_reader.sv */
// request reader, decodes commands and packs write data into line RAM beats
module request_reader (
    input  logic                  itf,
    input  logic                  arst_n,
    input  logic                  in_empty,
    input  bridge_pkg::word_t     in_data,
    output logic                  in_rd,
    input  logic                  writer_busy,
    input  logic                  job_ready,
    output logic                  job_valid,
    output bridge_pkg::line_idx_t job_line,
    output logic                  job_write,
    output logic                  wr_en,
    output bridge_pkg::ram_addr_t wr_addr,
    output bridge_pkg::beat_t     wr_beat
);

    typedef enum logic [1:0] {
        s_idle,
        s_pack,
        s_commit,
        s_offer
    } state_t;

    state_t state, next_state;

    // command seen one cycle ago, consume now
    logic cmd_seen;
    // data word number within the write burst
    // bit 0 picks the half, bits 2..1 the beat
    logic [2:0] word_cnt;
    // even word waiting for its partner
    bridge_pkg::word_t low_q;
    // data word taken this cycle
    logic take;
    // stall the first pair while the writer may still read old data
    logic first_hold;
    logic last_word;

    assign first_hold = (word_cnt == 3'd1) && writer_busy;
    assign last_word = (word_cnt == 3'(bridge_pkg::WORDS_PER_LINE - 1));
    assign job_valid = (state == s_offer);

    always_comb begin
        next_state = state;
        in_rd = 1'b0;
        take = 1'b0;
        case (state)
            s_idle: begin
                // fwft fifo keeps the word until popped
                if (cmd_seen && !in_empty) begin
                    in_rd = 1'b1;
                    if (in_data[bridge_pkg::CMD_WRITE_BIT]) begin
                        next_state = s_pack;
                    end else begin
                        next_state = s_offer;
                    end
                end
            end
            s_pack: begin
                if (!in_empty && !first_hold) begin
                    in_rd = 1'b1;
                    take = 1'b1;
                    if (last_word) begin
                        next_state = s_commit;
                    end
                end
            end
            s_commit: begin
                // last beat goes into the ram this cycle
                next_state = s_offer;
            end
            s_offer: begin
                if (job_ready) begin
                    next_state = s_idle;
                end
            end
            default: begin
                next_state = s_idle;
            end
        endcase
    end

    // control state
    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
            cmd_seen <= 1'b0;
            word_cnt <= 3'd0;
            wr_en <= 1'b0;
        end else begin
            state <= next_state;
            cmd_seen <= (state == s_idle) && !in_empty && !cmd_seen;
            // odd word completes a beat, write it next cycle
            wr_en <= take && word_cnt[0];
            if (state == s_idle) begin
                word_cnt <= 3'd0;
            end else if (take) begin
                word_cnt <= word_cnt + 3'd1;
            end
        end
    end

    // command fields and beat data
    always_ff @(posedge itf) begin
        if (state == s_idle && in_rd) begin
            job_line <= in_data[bridge_pkg::CMD_LINE_LSB +: bridge_pkg::LINE_W];
            job_write <= in_data[bridge_pkg::CMD_WRITE_BIT];
        end
        if (take && !word_cnt[0]) begin
            low_q <= in_data;
        end
        if (take && word_cnt[0]) begin
            // odd word in the high half
            wr_beat <= {in_data, low_q};
            wr_addr <= {job_line, word_cnt[2:1]};
        end
    end

endmodule

/* rtl/line_ram.sv */
// line RAM, dual-port beat storage with a registered read
module line_ram (
    input  logic                  itf,
    input  logic                  wr_en,
    input  bridge_pkg::ram_addr_t wr_addr,
    input  bridge_pkg::beat_t     wr_beat,
    input  logic                  rd_en,
    input  bridge_pkg::ram_addr_t rd_addr,
    output bridge_pkg::beat_t     rd_beat
);

    // 64 lines of 4 beats
    // contents are undefined at power up
    bridge_pkg::beat_t mem [bridge_pkg::LINES * bridge_pkg::BEATS_PER_LINE];

    // write port, driven by the request reader
    always_ff @(posedge itf) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // read port, driven by the response writer
    // output register holds its beat until the next rd_en
    // the writer relies on this while the output fifo is full
    always_ff @(posedge itf) begin
        if (rd_en) begin
            rd_beat <= mem[rd_addr];
        end
    end

    // both enables come from reset-cleared control in other blocks
    // an unknown enable would corrupt a line or the held beat
    ap_en_known: assert property (
        @(posedge itf) !$isunknown({wr_en, rd_en})
    ) else $error("line_ram: unknown ram enable");

endmodule

/* rtl/bridge_pkg.sv */
// line bridge shared widths, types and command word constants
package bridge_pkg;

    // basic field widths
    localparam int WORD_W = 32;
    localparam int BEAT_W = 2 * WORD_W;
    localparam int LINE_W = 6;
    localparam int BEAT_IDX_W = 2;
    // address is line index then beat number
    localparam int ADDR_W = LINE_W + BEAT_IDX_W;

    // memory geometry
    localparam int LINES = 1 << LINE_W;
    localparam int BEATS_PER_LINE = 1 << BEAT_IDX_W;
    // two fifo words per beat
    localparam int WORDS_PER_LINE = 2 * BEATS_PER_LINE;

    // one fifo word
    typedef logic [WORD_W-1:0] word_t;
    // one ram beat, even word in the low half
    typedef logic [BEAT_W-1:0] beat_t;
    // line number from the command word
    typedef logic [LINE_W-1:0] line_idx_t;
    // beat number inside a line
    typedef logic [BEAT_IDX_W-1:0] beat_idx_t;
    // full ram address
    typedef logic [ADDR_W-1:0] ram_addr_t;

    // command word layout
    // bits 10..5 line index
    localparam int CMD_LINE_LSB = 5;
    // bit 0 set for a write request
    localparam int CMD_WRITE_BIT = 0;

    // reply word for a completed write
    localparam word_t ACK_WORD = '1;

endpackage
